// ==== l1_dcache.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/l2_bus_if.sv
verilog/dcache_tag_array.sv
verilog/plru_tree.sv
verilog/line_data_ram.sv
verilog/store_buffer.sv
verilog/line_fill_unit.sv
verilog/l2_bus_arbiter.sv
verilog/l1_dcache.sv
dv/tb_clock_gen.sv
dv/l1_dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the L1 data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
	--top-module l1_dcache_tb -Mdir obj_dir -f l1_dcache.f > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vl1_dcache_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" sim.log; then
	exit 1
fi
exit 0

// ==== dv/l1_dcache_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// L1 data cache testbench
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module l1_dcache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// About 40 accesses of under 20 cycles each fit well inside this limit
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int WAIT_CYCLES = 100;
	localparam int L2_LINES = 64;
	localparam logic [27:0] L2_BASE = 28'h0001200;

	logic                   clk;
	logic                   arst_n;
	logic                   access_i;
	logic                   write_i;
	logic [31:0]            addr_i;
	dcache_pkg::line_t      wdata_i;
	dcache_pkg::mask_t      wmask_i;
	logic                   hit_o;
	dcache_pkg::line_t      data_o;
	logic                   data_valid_o;
	logic                   stbuf_full_o;
	logic                   load_done_o;
	logic                   store_done_o;
	logic                   wb_cyc_o;
	logic                   wb_stb_o;
	logic                   wb_we_o;
	dcache_pkg::line_addr_t wb_adr_o;
	dcache_pkg::line_t      wb_dat_o;
	dcache_pkg::mask_t      wb_sel_o;
	dcache_pkg::line_t      wb_dat_i = '0;
	logic                   wb_ack_i = 1'b0;

	logic [31:0]            lfsr_q = 32'h8c53641a;
	dcache_pkg::line_t      l2_mem [L2_LINES];
	int                     ack_wait = -1;
	bit                     stall_ack = 1'b0;
	int                     errors = 0;
	int                     tests_run = 0;
	int                     tests_failed = 0;
	int                     cycle_cnt = 0;

	tb_clock_gen u_clk (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	l1_dcache UUT (
		.clk          (clk),
		.arst_n_i     (arst_n),
		.access_i     (access_i),
		.write_i      (write_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.wmask_i      (wmask_i),
		.hit_o        (hit_o),
		.data_o       (data_o),
		.data_valid_o (data_valid_o),
		.stbuf_full_o (stbuf_full_o),
		.load_done_o  (load_done_o),
		.store_done_o (store_done_o),
		.wb_cyc_o     (wb_cyc_o),
		.wb_stb_o     (wb_stb_o),
		.wb_we_o      (wb_we_o),
		.wb_adr_o     (wb_adr_o),
		.wb_dat_o     (wb_dat_o),
		.wb_sel_o     (wb_sel_o),
		.wb_dat_i     (wb_dat_i),
		.wb_ack_i     (wb_ack_i)
	);

	// Galois LFSR stepped once per bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (b)
			lfsr_q = lfsr_q ^ 32'h80200003;
		return b;
	endfunction

	function automatic dcache_pkg::line_t rand_line();
		dcache_pkg::line_t l;
		for (int i = 0; i < 128; i++)
			l[i] = lfsr_bit();
		return l;
	endfunction

	function automatic dcache_pkg::mask_t rand_mask();
		dcache_pkg::mask_t m;
		for (int i = 0; i < 16; i++)
			m[i] = lfsr_bit();
		return m;
	endfunction

	function automatic int rand_delay();
		int v;
		v = lfsr_bit() ? 1 : 0;
		v = v * 2 + (lfsr_bit() ? 1 : 0);
		return v % 3 + 1;
	endfunction

	// Masked bytes of the new line replace the old ones
	function automatic dcache_pkg::line_t merge_line(dcache_pkg::line_t old,
		dcache_pkg::line_t upd, dcache_pkg::mask_t m);
		dcache_pkg::line_t r;
		r = old;
		for (int b = 0; b < 16; b++)
			if (m[b])
				r[b*8 +: 8] = upd[b*8 +: 8];
		return r;
	endfunction

	function automatic logic [31:0] byte_addr(input int k);
		logic [27:0] la;
		la = L2_BASE + 28'(k);
		return {la, 4'h0};
	endfunction

	// L2 model acks for one cycle after a random wait
	always @(posedge clk)
	begin
		logic [27:0] off;
		#1;
		if (wb_ack_i)
			wb_ack_i = 1'b0;
		else if (wb_cyc_o && wb_stb_o && !stall_ack)
		begin
			if (ack_wait < 0)
				ack_wait = rand_delay();
			ack_wait--;
			if (ack_wait == 0)
			begin
				ack_wait = -1;
				off = 28'(wb_adr_o) - L2_BASE;
				if (off >= 28'(L2_LINES))
				begin
					$display("L2 access to line %h lies outside the modelled memory", wb_adr_o);
					errors++;
					wb_dat_i = '0;
				end
				else
				begin
					if (wb_we_o)
						l2_mem[off] = merge_line(l2_mem[off], wb_dat_o, wb_sel_o);
					wb_dat_i = l2_mem[off];
				end
				wb_ack_i = 1'b1;
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Run stopped after %0d cycles without finishing", cycle_cnt);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp)
		else
		begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_line(input string name, input dcache_pkg::line_t got,
		input dcache_pkg::line_t exp);
		assert (got === exp)
		else
		begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_done(input bit for_load, input string what);
		int n;
		bit seen;
		n = 0;
		seen = 0;
		while (!seen && n < WAIT_CYCLES)
		begin
			@(posedge clk);
			#1;
			seen = for_load ? load_done_o : store_done_o;
			n++;
		end
		assert (seen)
		else
		begin
			$display("%s did not pulse within %0d cycles", what, WAIT_CYCLES);
			errors++;
		end
	endtask

	task automatic wait_bus_busy();
		int n;
		n = 0;
		while (!wb_cyc_o && n < WAIT_CYCLES)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (wb_cyc_o)
		else
		begin
			$display("L2 bus stayed idle for %0d cycles after the miss", WAIT_CYCLES);
			errors++;
		end
	endtask

	// Read one line and check hit and data
	// A miss may wait for the fill
	task automatic read_check(input int k, input bit exp_hit, input dcache_pkg::line_t exp,
		input bit wait_fill);
		access_i = 1'b1;
		write_i  = 1'b0;
		addr_i   = byte_addr(k);
		@(posedge clk);
		#1;
		access_i = 1'b0;
		check_bit("hit_o", hit_o, exp_hit);
		if (hit_o)
		begin
			@(posedge clk);
			#1;
			check_bit("data_valid_o", data_valid_o, 1'b1);
			check_line("data_o", data_o, exp);
		end
		else if (wait_fill)
			wait_done(1'b1, "load_done_o");
	endtask

	task automatic write_line(input int k, input dcache_pkg::line_t w,
		input dcache_pkg::mask_t m, input bit exp_hit);
		check_bit("stbuf_full_o", stbuf_full_o, 1'b0);
		access_i = 1'b1;
		write_i  = 1'b1;
		addr_i   = byte_addr(k);
		wdata_i  = w;
		wmask_i  = m;
		@(posedge clk);
		#1;
		access_i = 1'b0;
		write_i  = 1'b0;
		check_bit("hit_o", hit_o, exp_hit);
	endtask

	task automatic test_reset();
		check_bit("hit_o", hit_o, 1'b0);
		check_bit("data_valid_o", data_valid_o, 1'b0);
		check_bit("stbuf_full_o", stbuf_full_o, 1'b0);
		check_bit("load_done_o", load_done_o, 1'b0);
		check_bit("store_done_o", store_done_o, 1'b0);
		check_bit("wb_cyc_o", wb_cyc_o, 1'b0);
		check_bit("wb_stb_o", wb_stb_o, 1'b0);
		read_check(1, 1'b0, '0, 1'b1);
		read_check(1, 1'b1, l2_mem[1], 1'b0);
	endtask

	task automatic test_write_hit();
		dcache_pkg::line_t w;
		dcache_pkg::mask_t m;
		dcache_pkg::line_t exp;
		w   = rand_line();
		m   = rand_mask();
		exp = merge_line(l2_mem[1], w, m);
		write_line(1, w, m, 1'b1);
		wait_done(1'b0, "store_done_o");
		check_line("l2 line", l2_mem[1], exp);
		read_check(1, 1'b1, exp, 1'b0);
	endtask

	task automatic test_write_miss();
		dcache_pkg::line_t w;
		dcache_pkg::mask_t m;
		dcache_pkg::line_t exp;
		w   = rand_line();
		m   = rand_mask();
		exp = merge_line(l2_mem[2], w, m);
		write_line(2, w, m, 1'b0);
		wait_done(1'b0, "store_done_o");
		check_line("l2 line", l2_mem[2], exp);
		// Write misses do not allocate the line
		read_check(2, 1'b0, '0, 1'b1);
		read_check(2, 1'b1, exp, 1'b0);
	endtask

	task automatic test_backpressure();
		dcache_pkg::line_t w;
		dcache_pkg::mask_t m;
		dcache_pkg::line_t exp;

		// Fill of line 4 holds the bus while a store to the same line waits
		w   = rand_line();
		m   = rand_mask();
		exp = merge_line(l2_mem[4], w, m);
		stall_ack = 1'b1;
		read_check(4, 1'b0, '0, 1'b0);
		wait_bus_busy();
		check_bit("wb_we_o", wb_we_o, 1'b0);
		write_line(4, w, m, 1'b0);
		check_bit("stbuf_full_o", stbuf_full_o, 1'b1);

		// The fill brings the old line and only forwarding shows the store
		stall_ack = 1'b0;
		wait_done(1'b1, "load_done_o");
		stall_ack = 1'b1;
		read_check(4, 1'b1, exp, 1'b0);
		check_bit("stbuf_full_o", stbuf_full_o, 1'b1);
		stall_ack = 1'b0;
		wait_done(1'b0, "store_done_o");
		check_line("l2 line", l2_mem[4], exp);

		// The fill of an uncached line queues behind the store
		w   = rand_line();
		m   = rand_mask();
		exp = merge_line(l2_mem[3], w, m);
		stall_ack = 1'b1;
		write_line(3, w, m, 1'b0);
		check_bit("stbuf_full_o", stbuf_full_o, 1'b1);
		read_check(3, 1'b0, '0, 1'b0);
		stall_ack = 1'b0;
		wait_done(1'b0, "store_done_o");
		wait_done(1'b1, "load_done_o");
		read_check(3, 1'b1, exp, 1'b0);
	endtask

	task automatic test_replacement();
		int lines [5];
		lines = '{5, 13, 21, 29, 37};
		// A, B, C, D land in ways 0, 2, 1, 3 of set 5
		for (int i = 0; i < 4; i++)
		begin
			read_check(lines[i], 1'b0, '0, 1'b1);
			read_check(lines[i], 1'b1, l2_mem[lines[i]], 1'b0);
		end
		read_check(lines[0], 1'b1, l2_mem[lines[0]], 1'b0);
		// Reading A turns the root to the right pair whose child points at way 2 with B
		read_check(lines[4], 1'b0, '0, 1'b1);
		read_check(lines[4], 1'b1, l2_mem[lines[4]], 1'b0);
		read_check(lines[0], 1'b1, l2_mem[lines[0]], 1'b0);
		read_check(lines[2], 1'b1, l2_mem[lines[2]], 1'b0);
		read_check(lines[3], 1'b1, l2_mem[lines[3]], 1'b0);
		read_check(lines[4], 1'b1, l2_mem[lines[4]], 1'b0);
		read_check(lines[1], 1'b0, '0, 1'b1);
	endtask

	task automatic finish_test(input string name, input int start);
		tests_run++;
		if (errors == start)
			$display("%s: passed", name);
		else
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - start);
		end
	endtask

	initial
	begin
		int start;
		access_i = 1'b0;
		write_i  = 1'b0;
		addr_i   = '0;
		wdata_i  = '0;
		wmask_i  = '0;
		for (int i = 0; i < L2_LINES; i++)
			l2_mem[i] = rand_line();

		wait (arst_n === 1'b1);
		@(posedge clk);
		#1;

		start = errors;
		test_reset();
		finish_test("reset and first fill", start);
		start = errors;
		test_write_hit();
		finish_test("write hit", start);
		start = errors;
		test_write_miss();
		finish_test("write miss", start);
		start = errors;
		test_backpressure();
		finish_test("back-pressure and forwarding", start);
		start = errors;
		test_replacement();
		finish_test("replacement", start);

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Clock and reset
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic arst_n_o
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;
	end

	// Reset held for four rising edges
	initial
	begin
		arst_n_o = 1'b0;
		repeat (4) @(posedge clk_o);
		#1 arst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verilog/l1_dcache.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// L1 data cache
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "dcache_settings.svh"

module l1_dcache (
	input  wire logic                          clk,
	input  wire logic                          arst_n_i,
	input  wire logic                          access_i,
	input  wire logic                          write_i,
	input  wire logic [`DCACHE_ADDR_WIDTH-1:0] addr_i,
	input  wire dcache_pkg::line_t             wdata_i,
	input  wire dcache_pkg::mask_t             wmask_i,
	output logic                               hit_o,
	output dcache_pkg::line_t                  data_o,
	output logic                               data_valid_o,
	output logic                               stbuf_full_o,
	output logic                               load_done_o,
	output logic                               store_done_o,
	output logic                               wb_cyc_o,
	output logic                               wb_stb_o,
	output logic                               wb_we_o,
	output dcache_pkg::line_addr_t             wb_adr_o,
	output dcache_pkg::line_t                  wb_dat_o,
	output dcache_pkg::mask_t                  wb_sel_o,
	input  wire dcache_pkg::line_t             wb_dat_i,
	input  wire logic                          wb_ack_i
);

	dcache_pkg::set_t       req_set;
	dcache_pkg::tag_t       req_tag;
	logic                   req;
	logic                   stbuf_wr;

	// Pipeline stage after the tag read
	logic                   acc_q;
	logic                   wr_q;
	logic                   rd_hit_q;
	dcache_pkg::set_t       set_q;
	dcache_pkg::tag_t       tag_q;
	dcache_pkg::line_t      wdata_q;
	dcache_pkg::mask_t      wmask_q;
	dcache_pkg::line_addr_t rd_line_q;

	logic                   hit;
	dcache_pkg::way_t       hit_way;
	dcache_pkg::way_t       victim;
	logic                   read_miss;
	logic                   write_hit;
	logic                   inval;
	logic                   fill;
	dcache_pkg::way_t       fill_way;
	dcache_pkg::set_t       fill_set;
	dcache_pkg::tag_t       fill_tag;
	dcache_pkg::line_t      fill_data;
	dcache_pkg::line_t      ram_rdata;
	dcache_pkg::line_t      fwd_data;
	dcache_pkg::mask_t      fwd_mask;

	l2_bus_if fill_bus ();
	l2_bus_if store_bus ();
	l2_bus_if l2_bus ();

	assign req_set = addr_i[`DCACHE_OFFSET_WIDTH +: `DCACHE_SET_WIDTH];
	assign req_tag = addr_i[`DCACHE_ADDR_WIDTH-1 -: `DCACHE_TAG_WIDTH];

	// A write waits while the store buffer is occupied, reads always go
	assign stbuf_wr = access_i && write_i && !stbuf_full_o;
	assign req      = access_i && (!write_i || !stbuf_full_o);

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			acc_q    <= 1'b0;
			wr_q     <= 1'b0;
			rd_hit_q <= 1'b0;
		end
		else
		begin
			acc_q    <= req;
			wr_q     <= write_i;
			rd_hit_q <= hit && !wr_q;
		end
	end

	always_ff @(posedge clk)
	begin
		set_q     <= req_set;
		tag_q     <= req_tag;
		wdata_q   <= wdata_i;
		wmask_q   <= wmask_i;
		rd_line_q <= {tag_q, set_q};
	end

	assign read_miss = acc_q && !wr_q && !hit;
	assign write_hit = hit && wr_q;

	dcache_tag_array u_tags (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.access_i  (req),
		.set_i     (req_set),
		.tag_i     (req_tag),
		.hit_o     (hit),
		.hit_way_o (hit_way),
		.inval_i   (inval),
		.fill_i    (fill),
		.upd_way_i (inval ? victim : fill_way),
		.upd_set_i (inval ? set_q : fill_set),
		.upd_tag_i (fill_tag)
	);

	// Write misses leave the tree alone
	plru_tree u_plru (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.rd_set_i   (set_q),
		.upd_i      (hit || read_miss),
		.upd_set_i  (set_q),
		.used_way_i (hit ? hit_way : victim),
		.victim_o   (victim)
	);

	line_data_ram u_data (
		.clk          (clk),
		.core_addr_i  ({set_q, hit_way}),
		.core_we_i    (write_hit),
		.core_be_i    (wmask_q),
		.core_wdata_i (wdata_q),
		.core_rdata_o (ram_rdata),
		.fill_addr_i  ({fill_set, fill_way}),
		.fill_we_i    (fill),
		.fill_data_i  (fill_data)
	);

	store_buffer u_stbuf (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.wr_i       (stbuf_wr),
		.addr_i     ({req_tag, req_set}),
		.data_i     (wdata_i),
		.mask_i     (wmask_i),
		.full_o     (stbuf_full_o),
		.fwd_addr_i (rd_line_q),
		.fwd_data_o (fwd_data),
		.fwd_mask_o (fwd_mask),
		.done_o     (store_done_o),
		.bus        (store_bus.master)
	);

	line_fill_unit u_fill (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.miss_i      (read_miss),
		.miss_addr_i ({tag_q, set_q}),
		.victim_i    (victim),
		.inval_o     (inval),
		.fill_o      (fill),
		.fill_way_o  (fill_way),
		.fill_set_o  (fill_set),
		.fill_tag_o  (fill_tag),
		.fill_data_o (fill_data),
		.done_o      (load_done_o),
		.bus         (fill_bus.master)
	);

	l2_bus_arbiter u_arb (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.m_store  (store_bus.slave),
		.m_fill   (fill_bus.slave),
		.l2       (l2_bus.master)
	);

	// Pending store bytes override the RAM copy lane by lane
	always_comb
	begin
		for (int b = 0; b < `DCACHE_LINE_BYTES; b++)
			data_o[b*8 +: 8] = fwd_mask[b] ? fwd_data[b*8 +: 8] : ram_rdata[b*8 +: 8];
	end

	assign hit_o        = hit;
	assign data_valid_o = rd_hit_q;

	assign wb_cyc_o     = l2_bus.cyc;
	assign wb_stb_o     = l2_bus.stb;
	assign wb_we_o      = l2_bus.we;
	assign wb_adr_o     = l2_bus.adr;
	assign wb_dat_o     = l2_bus.dat_w;
	assign wb_sel_o     = l2_bus.sel;
	assign l2_bus.dat_r = wb_dat_i;
	assign l2_bus.ack   = wb_ack_i;

endmodule

`default_nettype wire

// ==== verilog/l2_bus_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// L2 bus arbiter
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module l2_bus_arbiter (
	input  wire logic clk,
	input  wire logic arst_n_i,
	l2_bus_if.slave   m_store,
	l2_bus_if.slave   m_fill,
	l2_bus_if.master  l2
);

	logic gnt_valid_q;
	logic gnt_store_q;
	logic to_store;
	logic to_fill;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			gnt_valid_q <= 1'b0;
			gnt_store_q <= 1'b0;
		end
		else if (!gnt_valid_q)
		begin
			// Store buffer first when both ask in the same cycle
			if (m_store.cyc)
			begin
				gnt_valid_q <= 1'b1;
				gnt_store_q <= 1'b1;
			end
			else if (m_fill.cyc)
			begin
				gnt_valid_q <= 1'b1;
				gnt_store_q <= 1'b0;
			end
		end
		else if (l2.ack)
			gnt_valid_q <= 1'b0;
	end

	assign to_store = gnt_valid_q && gnt_store_q;
	assign to_fill  = gnt_valid_q && !gnt_store_q;

	assign l2.cyc   = to_store ? m_store.cyc   : (to_fill && m_fill.cyc);
	assign l2.stb   = to_store ? m_store.stb   : (to_fill && m_fill.stb);
	assign l2.we    = to_store ? m_store.we    : m_fill.we;
	assign l2.adr   = to_store ? m_store.adr   : m_fill.adr;
	assign l2.dat_w = to_store ? m_store.dat_w : m_fill.dat_w;
	assign l2.sel   = to_store ? m_store.sel   : m_fill.sel;

	// Waiting master sees no ack and keeps its request up
	assign m_store.ack   = to_store && l2.ack;
	assign m_store.dat_r = to_store ? l2.dat_r : '0;
	assign m_fill.ack    = to_fill && l2.ack;
	assign m_fill.dat_r  = to_fill ? l2.dat_r : '0;

	a_hold_until_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
		l2.cyc && !l2.ack |=> $stable(l2.adr) && $stable(l2.we));

endmodule

`default_nettype wire

// ==== verilog/line_fill_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Line fill engine
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module line_fill_unit (
	input  wire logic                   clk,
	input  wire logic                   arst_n_i,
	input  wire logic                   miss_i,
	input  wire dcache_pkg::line_addr_t miss_addr_i,
	input  wire dcache_pkg::way_t       victim_i,
	output logic                        inval_o,
	output logic                        fill_o,
	output dcache_pkg::way_t            fill_way_o,
	output dcache_pkg::set_t            fill_set_o,
	output dcache_pkg::tag_t            fill_tag_o,
	output dcache_pkg::line_t           fill_data_o,
	output logic                        done_o,
	l2_bus_if.master                    bus
);

	logic                   busy_q;
	logic                   done_q;
	dcache_pkg::line_addr_t addr_q;
	dcache_pkg::way_t       way_q;

	// Misses arriving while busy are dropped
	assign inval_o = miss_i && !busy_q;
	assign fill_o  = busy_q && bus.ack;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= fill_o;
			if (inval_o)
				busy_q <= 1'b1;
			else if (fill_o)
				busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (inval_o)
		begin
			addr_q <= miss_addr_i;
			way_q  <= victim_i;
		end
	end

	assign fill_way_o  = way_q;
	assign fill_set_o  = addr_q.set;
	assign fill_tag_o  = addr_q.tag;
	assign fill_data_o = bus.dat_r;
	assign done_o      = done_q;

	// Full line read
	assign bus.cyc   = busy_q;
	assign bus.stb   = busy_q;
	assign bus.we    = 1'b0;
	assign bus.adr   = addr_q;
	assign bus.dat_w = '0;
	assign bus.sel   = '1;

endmodule

`default_nettype wire

// ==== verilog/store_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Store buffer
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module store_buffer (
	input  wire logic                   clk,
	input  wire logic                   arst_n_i,
	input  wire logic                   wr_i,
	input  wire dcache_pkg::line_addr_t addr_i,
	input  wire dcache_pkg::line_t      data_i,
	input  wire dcache_pkg::mask_t      mask_i,
	output logic                        full_o,
	input  wire dcache_pkg::line_addr_t fwd_addr_i,
	output dcache_pkg::line_t           fwd_data_o,
	output dcache_pkg::mask_t           fwd_mask_o,
	output logic                        done_o,
	l2_bus_if.master                    bus
);

	logic                   full_q;
	logic                   done_q;
	dcache_pkg::line_addr_t addr_q;
	dcache_pkg::line_t      data_q;
	dcache_pkg::mask_t      mask_q;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			full_q <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= full_q && bus.ack;
			if (wr_i)
				full_q <= 1'b1;
			else if (full_q && bus.ack)
				full_q <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_i)
		begin
			addr_q <= addr_i;
			data_q <= data_i;
			mask_q <= mask_i;
		end
	end

	// Write goes out as soon as the entry is filled
	assign bus.cyc   = full_q;
	assign bus.stb   = full_q;
	assign bus.we    = 1'b1;
	assign bus.adr   = addr_q;
	assign bus.dat_w = data_q;
	assign bus.sel   = mask_q;

	assign full_o     = full_q;
	assign done_o     = done_q;
	assign fwd_data_o = data_q;
	assign fwd_mask_o = (full_q && fwd_addr_i == addr_q) ? mask_q : '0;

	// Core must hold a write while the single entry is busy
	a_no_wr_when_full: assert property (@(posedge clk) disable iff (!arst_n_i)
		wr_i |-> !full_o);

endmodule

`default_nettype wire

// ==== verilog/line_data_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Line data RAM
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "dcache_settings.svh"

module line_data_ram (
	input  wire logic                                         clk,
	input  wire logic [`DCACHE_SET_WIDTH+`DCACHE_WAY_WIDTH-1:0] core_addr_i,
	input  wire logic                                         core_we_i,
	input  wire dcache_pkg::mask_t                            core_be_i,
	input  wire dcache_pkg::line_t                            core_wdata_i,
	output dcache_pkg::line_t                                 core_rdata_o,
	input  wire logic [`DCACHE_SET_WIDTH+`DCACHE_WAY_WIDTH-1:0] fill_addr_i,
	input  wire logic                                         fill_we_i,
	input  wire dcache_pkg::line_t                            fill_data_i
);

	// One entry per set and way
	dcache_pkg::line_t mem_q [`DCACHE_NUM_SETS*`DCACHE_NUM_WAYS];

	always_ff @(posedge clk)
	begin
		// Byte lanes from the core
		for (int b = 0; b < `DCACHE_LINE_BYTES; b++)
		begin
			if (core_we_i && core_be_i[b])
				mem_q[core_addr_i][b*8 +: 8] <= core_wdata_i[b*8 +: 8];
		end

		// Whole line from L2
		if (fill_we_i)
			mem_q[fill_addr_i] <= fill_data_i;

		core_rdata_o <= mem_q[core_addr_i];
	end

endmodule

`default_nettype wire

// ==== verilog/plru_tree.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Tree pseudo-LRU
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "dcache_settings.svh"

module plru_tree (
	input  wire logic             clk,
	input  wire logic             arst_n_i,
	input  wire dcache_pkg::set_t rd_set_i,
	input  wire logic             upd_i,
	input  wire dcache_pkg::set_t upd_set_i,
	input  wire dcache_pkg::way_t used_way_i,
	output dcache_pkg::way_t      victim_o
);

	dcache_pkg::plru_t tree_q [`DCACHE_NUM_SETS];
	dcache_pkg::plru_t cur;

	// Root picks the pair, bit 1 or 2 picks the way inside it
	always_comb
	begin
		cur      = tree_q[rd_set_i];
		victim_o = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			for (int s = 0; s < `DCACHE_NUM_SETS; s++)
				tree_q[s] <= '0;
		end
		else if (upd_i)
		begin
			// Point root and child away from the way just used
			tree_q[upd_set_i][0] <= ~used_way_i[1];
			if (used_way_i[1])
				tree_q[upd_set_i][2] <= ~used_way_i[0];
			else
				tree_q[upd_set_i][1] <= ~used_way_i[0];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dcache_tag_array.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Tag array
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "dcache_settings.svh"

module dcache_tag_array (
	input  wire logic             clk,
	input  wire logic             arst_n_i,
	input  wire logic             access_i,
	input  wire dcache_pkg::set_t set_i,
	input  wire dcache_pkg::tag_t tag_i,
	output logic                  hit_o,
	output dcache_pkg::way_t      hit_way_o,
	input  wire logic             inval_i,
	input  wire logic             fill_i,
	input  wire dcache_pkg::way_t upd_way_i,
	input  wire dcache_pkg::set_t upd_set_i,
	input  wire dcache_pkg::tag_t upd_tag_i
);

	dcache_pkg::tag_t             tags_q [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];
	logic [`DCACHE_NUM_WAYS-1:0]  valid_q [`DCACHE_NUM_SETS];

	// Stage registers for the compare in the following cycle
	dcache_pkg::tag_t             rd_tag_q [`DCACHE_NUM_WAYS];
	logic [`DCACHE_NUM_WAYS-1:0]  rd_valid_q;
	dcache_pkg::tag_t             tag_q;
	logic                         acc_q;

	always_ff @(posedge clk)
	begin
		if (fill_i)
			tags_q[upd_set_i][upd_way_i] <= upd_tag_i;
		for (int w = 0; w < `DCACHE_NUM_WAYS; w++)
			rd_tag_q[w] <= tags_q[set_i][w];
		tag_q <= tag_i;
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			for (int s = 0; s < `DCACHE_NUM_SETS; s++)
				valid_q[s] <= '0;
			rd_valid_q <= '0;
			acc_q      <= 1'b0;
		end
		else
		begin
			// Invalidate at miss start, set valid when the line arrives
			if (inval_i)
				valid_q[upd_set_i][upd_way_i] <= 1'b0;
			else if (fill_i)
				valid_q[upd_set_i][upd_way_i] <= 1'b1;
			rd_valid_q <= valid_q[set_i];
			acc_q      <= access_i;
		end
	end

	always_comb
	begin
		hit_o     = 1'b0;
		hit_way_o = '0;
		for (int w = 0; w < `DCACHE_NUM_WAYS; w++)
		begin
			if (rd_valid_q[w] && rd_tag_q[w] == tag_q)
			begin
				hit_o     = acc_q;
				hit_way_o = dcache_pkg::way_t'(w);
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/l2_bus_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// L2 Wishbone bus
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

interface l2_bus_if;

	logic                   cyc;
	logic                   stb;
	logic                   we;
	dcache_pkg::line_addr_t adr;
	dcache_pkg::line_t      dat_w;
	dcache_pkg::mask_t      sel;
	dcache_pkg::line_t      dat_r;
	logic                   ack;

	// Classic cycle, master holds everything until ack
	modport master (
		output cyc, stb, we, adr, dat_w, sel,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w, sel,
		output dat_r, ack
	);

endinterface

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Data cache types
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

	typedef logic [`DCACHE_LINE_BYTES*8-1:0] line_t;
	typedef logic [`DCACHE_LINE_BYTES-1:0]   mask_t;
	typedef logic [`DCACHE_TAG_WIDTH-1:0]    tag_t;
	typedef logic [`DCACHE_SET_WIDTH-1:0]    set_t;
	typedef logic [`DCACHE_WAY_WIDTH-1:0]    way_t;

	// L2 line address, tag in the upper bits
	typedef struct packed {
		tag_t tag;
		set_t set;
	} line_addr_t;

	// Tree bits: root, left node, right node
	typedef logic [`DCACHE_NUM_WAYS-2:0] plru_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_settings.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// Cache geometry
// ~~~~~~~~~~~~~~~~~~~~

`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

`define DCACHE_NUM_WAYS     4
`define DCACHE_NUM_SETS     8
`define DCACHE_LINE_BYTES   16
`define DCACHE_ADDR_WIDTH   32

// Address split, offset at the bottom and tag at the top
`define DCACHE_OFFSET_WIDTH ($clog2(`DCACHE_LINE_BYTES))
`define DCACHE_SET_WIDTH    ($clog2(`DCACHE_NUM_SETS))
`define DCACHE_WAY_WIDTH    ($clog2(`DCACHE_NUM_WAYS))
`define DCACHE_TAG_WIDTH    (`DCACHE_ADDR_WIDTH - `DCACHE_SET_WIDTH - `DCACHE_OFFSET_WIDTH)

`endif
